// ==== design/scurve_config.svh ====
`ifndef SCURVE_CONFIG_SVH
`define SCURVE_CONFIG_SVH

// Channels on one front-end ASIC
`define SCURVE_CHN_NUM 64

// Result words buffered before the USB FIFO
`define SCURVE_FIFO_DEPTH 16

// Clk cycles per count-mode injection tick
// Kept short so simulation runs quickly
`define SCURVE_TICK_DIV 8

// Flops in every pin synchronizer
`define SCURVE_SYNC_STAGES 2

`endif

// ==== design/scurve_pkg.sv ====
`include "scurve_config.svh"

package scurve_pkg;

    // Channel index
    typedef logic [$clog2(`SCURVE_CHN_NUM)-1:0] chn_t;

    // Threshold DAC code
    typedef logic [9:0] dac_t;

    // Injection and hit counts, also the result word
    typedef logic [15:0] cnt_t;

    // Trigger window length in Clk cycles
    typedef logic [3:0] delay_t;

    // One bit per channel for charge injection
    typedef logic [`SCURVE_CHN_NUM-1:0] chn_mask_t;

    // Three discriminator bits per channel
    // A set bit masks that discriminator
    typedef logic [3*`SCURVE_CHN_NUM-1:0] disc_mask_t;

    // Sweep controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        WAIT_CFG,
        MEASURE,
        WAIT_MEAS,
        NEXT,
        DRAIN,
        WAIT_HOST
    } sweep_state_t;

endpackage

// ==== design/scurve_meas_if.sv ====
interface scurve_meas_if import scurve_pkg::*; ();

    // Begin one S-curve point
    logic start;
    // Injections or ticks per point, held during a measurement
    cnt_t cpt_max;
    // Hit or edge count of the finished point
    cnt_t result;
    logic result_valid;
    // End of point, same cycle as result_valid
    logic done;

    // Sweep controller side
    modport ctrl (output start, output cpt_max, input done);

    // Single-point measurer side
    modport meas (input start, input cpt_max, output result, output result_valid,
                  output done);

    // Data FIFO write side
    modport sink (input result, input result_valid);

endinterface

// ==== design/inject_pulse_gen.sv ====
`include "scurve_config.svh"

module inject_pulse_gen (
    input  logic Clk,
    input  logic reset_n,
    input  logic trig_effi_mode,
    input  logic ext_pulse,
    output logic inject
);

    localparam int SYNC_N = `SCURVE_SYNC_STAGES;
    localparam int TICK_W = $clog2(`SCURVE_TICK_DIV + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`SCURVE_TICK_DIV - 1);

    logic [SYNC_N-1:0] ext_sync;
    logic              ext_prev;
    logic              ext_rise;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;

    ////////////////////////////////////////////////////////////
    // Trigger mode source
    ////////////////////////////////////////////////////////////

    // External pulse clock into the Clk domain
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            ext_sync <= '0;
            ext_prev <= 1'b0;
        end else begin
            ext_sync <= {ext_sync[SYNC_N-2:0], ext_pulse};
            ext_prev <= ext_sync[SYNC_N-1];
        end
    end

    assign ext_rise = ext_sync[SYNC_N-1] & ~ext_prev;

    ////////////////////////////////////////////////////////////
    // Count mode source
    ////////////////////////////////////////////////////////////

    // Free-running divider, parked at zero in trigger mode
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            tick_cnt <= '0;
        end else if (trig_effi_mode || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = !trig_effi_mode && (tick_cnt == TICK_LAST);

    // Registered strobe, one Clk wide
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            inject <= 1'b0;
        end else begin
            inject <= trig_effi_mode ? ext_rise : tick;
        end
    end

    // Each injection is a lone strobe in both modes
    assert property (@(posedge Clk) disable iff (!reset_n) inject |=> !inject)
        else $error("inject high for two cycles");

endmodule

// ==== design/scurve_single_test.sv ====
`include "scurve_config.svh"

module scurve_single_test import scurve_pkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        trig_effi_mode,
    input  logic        inject,
    input  logic        trigger0_n,
    input  logic        trigger1_n,
    input  logic        trigger2_n,
    input  delay_t      trigger_delay,
    scurve_meas_if.meas meas
);

    localparam int SYNC_N = `SCURVE_SYNC_STAGES;

    logic [SYNC_N-1:0][2:0] trig_sync;
    logic   trig_any;
    logic   trig_any_d;
    logic   trig_fall;

    logic   busy;
    cnt_t   inj_cnt;
    cnt_t   hit_cnt;
    delay_t win_cnt;
    logic   hit_flag;
    logic   finish;
    logic   done_r;
    cnt_t   result_r;

    ////////////////////////////////////////////////////////////
    // Trigger conditioning
    ////////////////////////////////////////////////////////////

    // Trigger lines idle high
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            trig_sync  <= '1;
            trig_any_d <= 1'b0;
        end else begin
            trig_sync  <= {trig_sync[SYNC_N-2:0], {trigger2_n, trigger1_n, trigger0_n}};
            trig_any_d <= trig_any;
        end
    end

    // Any discriminator fired
    assign trig_any  = ~&trig_sync[SYNC_N-1];
    assign trig_fall = trig_any & ~trig_any_d;

    ////////////////////////////////////////////////////////////
    // Point measurement
    ////////////////////////////////////////////////////////////

    // All injections seen and the last window closed
    assign finish = busy && (inj_cnt == meas.cpt_max) && (win_cnt == '0);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            inj_cnt  <= '0;
            hit_cnt  <= '0;
            win_cnt  <= '0;
            hit_flag <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (meas.start) begin
                busy     <= 1'b1;
                inj_cnt  <= '0;
                hit_cnt  <= '0;
                win_cnt  <= '0;
                hit_flag <= 1'b0;
            end else if (finish) begin
                busy   <= 1'b0;
                done_r <= 1'b1;
            end else if (busy) begin
                // Trigger mode takes one hit per open window
                if (trig_effi_mode) begin
                    if (trig_fall && (win_cnt != '0) && !hit_flag) begin
                        hit_cnt  <= hit_cnt + 1'b1;
                        hit_flag <= 1'b1;
                    end
                end else if (trig_fall) begin
                    hit_cnt <= hit_cnt + 1'b1;
                end
                // Late injections past cpt_max are ignored
                if (inject && (inj_cnt != meas.cpt_max)) begin
                    inj_cnt <= inj_cnt + 1'b1;
                    if (trig_effi_mode) begin
                        win_cnt  <= trigger_delay;
                        hit_flag <= 1'b0;
                    end
                end else if (win_cnt != '0) begin
                    win_cnt <= win_cnt - 1'b1;
                end
            end
        end
    end

    // Result word
    always_ff @(posedge Clk) begin
        if (finish) begin
            result_r <= hit_cnt;
        end
    end

    assign meas.result       = result_r;
    assign meas.result_valid = done_r;
    assign meas.done         = done_r;

    // Controller waits for done before the next point
    assert property (@(posedge Clk) disable iff (!reset_n) meas.start |-> !busy)
        else $error("measurement start while busy");

endmodule

// ==== design/scurve_data_fifo.sv ====
`include "scurve_config.svh"

module scurve_data_fifo import scurve_pkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    scurve_meas_if.sink wr,
    input  logic        rd_en,
    output cnt_t        dout,
    output logic        empty,
    output logic        full
);

    localparam int DEPTH = `SCURVE_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    cnt_t          mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_fire;
    logic          rd_fire;

    assign wr_fire = wr.result_valid && !full;
    assign rd_fire = rd_en && !empty;

    // Storage
    always_ff @(posedge Clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr.result;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // First word falls through
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));

    // Sweep controller holds off measurements while full
    assert property (@(posedge Clk) disable iff (!reset_n) wr.result_valid |-> !full)
        else $error("data FIFO write while full");

    // USB drain only pops real words
    assert property (@(posedge Clk) disable iff (!reset_n) rd_en |-> !empty)
        else $error("data FIFO read while empty");

endmodule

// ==== design/scurve_test_control.sv ====
`include "scurve_config.svh"

module scurve_test_control import scurve_pkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        test_start,
    input  logic        trig_effi_mode,
    input  logic        single_chn_mode,
    input  chn_t        single_chn,
    input  logic        ctest_inject,
    input  cnt_t        cpt_max,
    input  cnt_t        counter_max,
    input  dac_t        start_dac,
    input  dac_t        end_dac,
    input  logic        unmask_all,
    input  logic        config_done,
    scurve_meas_if.ctrl meas,
    input  cnt_t        fifo_dout,
    input  logic        fifo_empty,
    input  logic        fifo_full,
    output logic        fifo_rd_en,
    output chn_mask_t   ctest_chn,
    output dac_t        dac_code,
    output disc_mask_t  disc_mask,
    output logic        sc_param_load,
    output logic        force_ext_raz,
    input  logic        usb_fifo_full,
    output logic        usb_fifo_wr_en,
    output cnt_t        usb_fifo_wr_data,
    input  logic        data_transmit_done,
    output logic        test_done
);

    localparam chn_t LAST_CHN = chn_t'(`SCURVE_CHN_NUM - 1);

    sweep_state_t state;
    logic         start_d1;
    logic         start_d2;
    logic         start_pulse;
    chn_t         chn;
    dac_t         dac;

    // Start button edge
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            start_d1 <= 1'b0;
            start_d2 <= 1'b0;
        end else begin
            start_d1 <= test_start;
            start_d2 <= start_d1;
        end
    end

    assign start_pulse = start_d1 & ~start_d2;

    // Injection count in trigger mode, tick count in count mode
    assign meas.cpt_max = trig_effi_mode ? cpt_max : counter_max;

    ////////////////////////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= IDLE;
            chn           <= '0;
            dac           <= '0;
            ctest_chn     <= '0;
            dac_code      <= '0;
            disc_mask     <= '1;
            sc_param_load <= 1'b0;
            force_ext_raz <= 1'b0;
            meas.start    <= 1'b0;
            test_done     <= 1'b0;
        end else begin
            // Strobes default low
            sc_param_load <= 1'b0;
            meas.start    <= 1'b0;
            test_done     <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_pulse) begin
                        chn   <= single_chn_mode ? single_chn : '0;
                        dac   <= start_dac;
                        state <= LOAD;
                    end
                end
                // Slow-control word for this point
                LOAD: begin
                    ctest_chn     <= (single_chn_mode && !ctest_inject) ?
                                     '0 : (chn_mask_t'(1) << chn);
                    dac_code      <= dac;
                    disc_mask     <= unmask_all ?
                                     '0 : ~(disc_mask_t'(3'b111) << (3 * chn));
                    sc_param_load <= 1'b1;
                    force_ext_raz <= 1'b1;
                    state         <= WAIT_CFG;
                end
                WAIT_CFG: begin
                    if (config_done) begin
                        if (!fifo_full) begin
                            meas.start <= 1'b1;
                            state      <= WAIT_MEAS;
                        end else begin
                            state <= MEASURE;
                        end
                    end
                end
                // Held here until the FIFO has room
                MEASURE: begin
                    if (!fifo_full) begin
                        meas.start <= 1'b1;
                        state      <= WAIT_MEAS;
                    end
                end
                WAIT_MEAS: begin
                    if (meas.done) begin
                        state <= NEXT;
                    end
                end
                // DAC inner loop, channel outer loop
                NEXT: begin
                    if (dac < end_dac) begin
                        dac   <= dac + 1'b1;
                        state <= LOAD;
                    end else if (!single_chn_mode && (chn != LAST_CHN)) begin
                        chn   <= chn + 1'b1;
                        dac   <= start_dac;
                        state <= LOAD;
                    end else begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (fifo_empty) begin
                        state <= WAIT_HOST;
                    end
                end
                // Host confirms all words arrived
                WAIT_HOST: begin
                    if (data_transmit_done) begin
                        test_done     <= 1'b1;
                        force_ext_raz <= 1'b0;
                        state         <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // USB drain
    ////////////////////////////////////////////////////////////

    // Runs alongside the sweep
    assign usb_fifo_wr_en   = !fifo_empty && !usb_fifo_full;
    assign usb_fifo_wr_data = fifo_dout;
    assign fifo_rd_en       = usb_fifo_wr_en;

endmodule

// ==== design/scurve_test_top.sv ====
module scurve_test_top import scurve_pkg::*; (
    input  logic       Clk,
    input  logic       reset_n,
    // Test setup
    input  logic       test_start,
    input  logic       trig_effi_mode,
    input  logic       single_chn_mode,
    input  chn_t       single_chn,
    input  logic       ctest_inject,
    input  cnt_t       cpt_max,
    input  cnt_t       counter_max,
    input  dac_t       start_dac,
    input  dac_t       end_dac,
    input  delay_t     trigger_delay,
    input  logic       unmask_all,
    // ASIC slow control
    input  logic       config_done,
    output chn_mask_t  ctest_chn,
    output dac_t       dac_code,
    output disc_mask_t disc_mask,
    output logic       sc_param_load,
    output logic       force_ext_raz,
    // ASIC pins
    input  logic       ext_pulse,
    input  logic       trigger0_n,
    input  logic       trigger1_n,
    input  logic       trigger2_n,
    // USB FIFO and host
    input  logic       usb_fifo_full,
    output logic       usb_fifo_wr_en,
    output cnt_t       usb_fifo_wr_data,
    input  logic       data_transmit_done,
    output logic       test_done
);

    logic inject;
    logic fifo_rd_en;
    cnt_t fifo_dout;
    logic fifo_empty;
    logic fifo_full;

    scurve_meas_if meas_if ();

    // Injection source
    inject_pulse_gen u_inject (
        .Clk            (Clk),
        .reset_n        (reset_n),
        .trig_effi_mode (trig_effi_mode),
        .ext_pulse      (ext_pulse),
        .inject         (inject)
    );

    // One S-curve point
    scurve_single_test u_single (
        .Clk            (Clk),
        .reset_n        (reset_n),
        .trig_effi_mode (trig_effi_mode),
        .inject         (inject),
        .trigger0_n     (trigger0_n),
        .trigger1_n     (trigger1_n),
        .trigger2_n     (trigger2_n),
        .trigger_delay  (trigger_delay),
        .meas           (meas_if.meas)
    );

    // Result buffer
    scurve_data_fifo u_fifo (
        .Clk     (Clk),
        .reset_n (reset_n),
        .wr      (meas_if.sink),
        .rd_en   (fifo_rd_en),
        .dout    (fifo_dout),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    // Sweep and drain
    scurve_test_control u_ctrl (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .test_start         (test_start),
        .trig_effi_mode     (trig_effi_mode),
        .single_chn_mode    (single_chn_mode),
        .single_chn         (single_chn),
        .ctest_inject       (ctest_inject),
        .cpt_max            (cpt_max),
        .counter_max        (counter_max),
        .start_dac          (start_dac),
        .end_dac            (end_dac),
        .unmask_all         (unmask_all),
        .config_done        (config_done),
        .meas               (meas_if.ctrl),
        .fifo_dout          (fifo_dout),
        .fifo_empty         (fifo_empty),
        .fifo_full          (fifo_full),
        .fifo_rd_en         (fifo_rd_en),
        .ctest_chn          (ctest_chn),
        .dac_code           (dac_code),
        .disc_mask          (disc_mask),
        .sc_param_load      (sc_param_load),
        .force_ext_raz      (force_ext_raz),
        .usb_fifo_full      (usb_fifo_full),
        .usb_fifo_wr_en     (usb_fifo_wr_en),
        .usb_fifo_wr_data   (usb_fifo_wr_data),
        .data_transmit_done (data_transmit_done),
        .test_done          (test_done)
    );

endmodule

// ==== tb/scurve_tb.sv ====
`include "scurve_config.svh"

module scurve_tb import scurve_pkg::*; ();

    localparam int WIN = 5;

    logic       Clk = 1'b0;
    logic       reset_n;
    logic       test_start;
    logic       trig_effi_mode;
    logic       single_chn_mode;
    chn_t       single_chn;
    logic       ctest_inject;
    cnt_t       cpt_max;
    cnt_t       counter_max;
    dac_t       start_dac;
    dac_t       end_dac;
    delay_t     trigger_delay;
    logic       unmask_all;
    logic       config_done = 1'b0;
    chn_mask_t  ctest_chn;
    dac_t       dac_code;
    disc_mask_t disc_mask;
    logic       sc_param_load;
    logic       force_ext_raz;
    logic       ext_pulse;
    logic       trigger0_n;
    logic       trigger1_n;
    logic       trigger2_n;
    logic       usb_fifo_full = 1'b0;
    logic       usb_fifo_wr_en;
    cnt_t       usb_fifo_wr_data;
    logic       data_transmit_done;
    logic       test_done;

    // ASIC and host model state
    int   cfg_wait = 0;
    int   cfg_count = 0;
    logic full_toggle;

    // Scoreboard
    cnt_t exp_q [$];
    int   words_seen = 0;
    int   load_count = 0;
    int   load_base = 0;
    int   done_count = 0;
    int   sweep_dacs = 1;
    int   load_chn;
    dac_t load_dac;

    scurve_test_top u_dut (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .test_start         (test_start),
        .trig_effi_mode     (trig_effi_mode),
        .single_chn_mode    (single_chn_mode),
        .single_chn         (single_chn),
        .ctest_inject       (ctest_inject),
        .cpt_max            (cpt_max),
        .counter_max        (counter_max),
        .start_dac          (start_dac),
        .end_dac            (end_dac),
        .trigger_delay      (trigger_delay),
        .unmask_all         (unmask_all),
        .config_done        (config_done),
        .ctest_chn          (ctest_chn),
        .dac_code           (dac_code),
        .disc_mask          (disc_mask),
        .sc_param_load      (sc_param_load),
        .force_ext_raz      (force_ext_raz),
        .ext_pulse          (ext_pulse),
        .trigger0_n         (trigger0_n),
        .trigger1_n         (trigger1_n),
        .trigger2_n         (trigger2_n),
        .usb_fifo_full      (usb_fifo_full),
        .usb_fifo_wr_en     (usb_fifo_wr_en),
        .usb_fifo_wr_data   (usb_fifo_wr_data),
        .data_transmit_done (data_transmit_done),
        .test_done          (test_done)
    );

    always #50 Clk = ~Clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Injection one-hot for a channel
    function automatic chn_mask_t ctest_onehot(input int chn, input logic single,
                                               input logic inj);
        chn_mask_t m;
        m = '0;
        if (!single || inj) begin
            m[chn] = 1'b1;
        end
        return m;
    endfunction

    // Three open discriminators for one channel, rest masked
    function automatic disc_mask_t disc_mask_for(input int chn, input logic unmask);
        disc_mask_t m;
        m = '1;
        if (unmask) begin
            m = '0;
        end else begin
            for (int b = 0; b < 3; b++) begin
                m[3*chn+b] = 1'b0;
            end
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////
    // ASIC and USB models
    ////////////////////////////////////////////////////////////

    // Slow-control answers 1 to 5 cycles after the load
    always @(posedge Clk) begin
        config_done <= 1'b0;
        if (sc_param_load) begin
            cfg_wait <= 1 + ($urandom % 5);
        end else if (cfg_wait != 0) begin
            cfg_wait <= cfg_wait - 1;
            if (cfg_wait == 1) begin
                config_done <= 1'b1;
                cfg_count   <= cfg_count + 1;
            end
        end
    end

    // USB FIFO busy at random
    always @(posedge Clk) begin
        usb_fifo_full <= full_toggle && ($urandom % 2 == 1);
    end

    ////////////////////////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////////////////////////

    // Slow-control word at every load
    always @(posedge Clk) begin
        if (reset_n && sc_param_load) begin
            load_chn = single_chn_mode ? int'(single_chn) : (load_count - load_base) / sweep_dacs;
            load_dac = dac_t'(int'(start_dac) + (load_count - load_base) % sweep_dacs);
            assert (dac_code == load_dac)
                else stop_on_error($sformatf("mismatch dac_code exp=%h got=%h",
                                             load_dac, dac_code));
            assert (ctest_chn == ctest_onehot(load_chn, single_chn_mode, ctest_inject))
                else stop_on_error($sformatf("mismatch ctest_chn exp=%h got=%h",
                    ctest_onehot(load_chn, single_chn_mode, ctest_inject), ctest_chn));
            assert (disc_mask == disc_mask_for(load_chn, unmask_all))
                else stop_on_error($sformatf("mismatch disc_mask exp=%h got=%h",
                    disc_mask_for(load_chn, unmask_all), disc_mask));
            load_count <= load_count + 1;
        end
    end

    // USB words in point order
    always @(posedge Clk) begin
        if (reset_n && usb_fifo_wr_en) begin
            assert (words_seen < exp_q.size())
                else stop_on_error("USB word written with no measured point pending");
            if (words_seen < exp_q.size()) begin
                assert (usb_fifo_wr_data == exp_q[words_seen])
                    else stop_on_error($sformatf("mismatch usb_fifo_wr_data exp=%h got=%h",
                                                 exp_q[words_seen], usb_fifo_wr_data));
            end
            words_seen <= words_seen + 1;
        end
    end

    // End of sweep
    always @(posedge Clk) begin
        if (reset_n && test_done) begin
            assert (words_seen == exp_q.size())
                else stop_on_error("test_done came before the last USB word");
            done_count <= done_count + 1;
        end
    end

    assert property (@(posedge Clk) disable iff (!reset_n) !(usb_fifo_wr_en && usb_fifo_full))
        else stop_on_error("usb_fifo_wr_en was high while usb_fifo_full was high");

    assert property (@(posedge Clk) disable iff (!reset_n) test_done |-> $past(data_transmit_done))
        else stop_on_error("test_done without data_transmit_done one cycle earlier");

    // Reset line to the ASIC follows the sweep
    assert property (@(posedge Clk) disable iff (!reset_n) sc_param_load |-> force_ext_raz)
        else stop_on_error("force_ext_raz low during a sweep point");
    assert property (@(posedge Clk) disable iff (!reset_n) test_done |-> !force_ext_raz)
        else stop_on_error("force_ext_raz still high at test_done");

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        assert (!sc_param_load && !test_done && !usb_fifo_wr_en && !force_ext_raz)
            else stop_on_error("strobe or force_ext_raz high after reset");
        assert (disc_mask == '1)
            else stop_on_error($sformatf("mismatch disc_mask exp=%h got=%h",
                                         ~disc_mask_t'(0), disc_mask));
    endtask

    task automatic drive_trigger(input int line, input logic level);
        case (line)
            0:       trigger0_n <= level;
            1:       trigger1_n <= level;
            default: trigger2_n <= level;
        endcase
    endtask

    task automatic wait_config_event(input int served);
        int n;
        n = 0;
        while (cfg_count == served) begin
            @(posedge Clk);
            n++;
            if (n > 200) begin
                stop_on_error("timeout waiting for config_done");
            end
        end
    endtask

    // One 24-cycle slot per injection; hit, late miss or no trigger
    task automatic emit_trig_point(input int n_inj);
        int low_at [16];
        int line_of [16];
        int hits;
        hits = 0;
        for (int i = 0; i < n_inj; i++) begin
            line_of[i] = $urandom % 3;
            case ($urandom % 3)
                0: begin
                    // Fall lands inside the window after sync
                    low_at[i] = 2 + ($urandom % WIN);
                    hits++;
                end
                1:       low_at[i] = WIN + 6;
                default: low_at[i] = -1;
            endcase
        end
        exp_q.push_back(cnt_t'(hits));
        for (int i = 0; i < n_inj; i++) begin
            for (int c = 0; c < 24; c++) begin
                @(posedge Clk);
                if (c == 0) begin
                    ext_pulse <= 1'b1;
                end else if (c == 3) begin
                    ext_pulse <= 1'b0;
                end
                if (c == low_at[i]) begin
                    drive_trigger(line_of[i], 1'b0);
                end else if (low_at[i] >= 0 && c == low_at[i] + 2) begin
                    drive_trigger(line_of[i], 1'b1);
                end
            end
        end
    endtask

    // Known number of edges, all well before the last tick
    task automatic emit_count_point();
        int edges;
        int line;
        edges = $urandom % 13;
        exp_q.push_back(cnt_t'(edges));
        for (int i = 0; i < edges; i++) begin
            line = $urandom % 3;
            @(posedge Clk);
            drive_trigger(line, 1'b0);
            repeat (2) @(posedge Clk);
            drive_trigger(line, 1'b1);
            @(posedge Clk);
        end
    endtask

    task automatic wait_all_words();
        int n;
        n = 0;
        while (words_seen != exp_q.size()) begin
            @(posedge Clk);
            n++;
            if (n > 1000) begin
                stop_on_error("timeout waiting for the last USB word");
            end
        end
    endtask

    task automatic wait_test_done(input int base);
        int n;
        n = 0;
        while (done_count == base) begin
            @(posedge Clk);
            n++;
            if (n > 50) begin
                stop_on_error("timeout waiting for test_done");
            end
        end
    endtask

    task automatic run_sweep(input logic trig, input logic single, input chn_t chn,
                             input logic inj, input logic unmask, input dac_t d0,
                             input dac_t d1, input int n_per);
        int n_points;
        int served;
        int done_base;
        n_points = single ? (int'(d1) - int'(d0) + 1) :
                            (int'(d1) - int'(d0) + 1) * `SCURVE_CHN_NUM;
        @(posedge Clk);
        trig_effi_mode  <= trig;
        single_chn_mode <= single;
        single_chn      <= chn;
        ctest_inject    <= inj;
        unmask_all      <= unmask;
        start_dac       <= d0;
        end_dac         <= d1;
        trigger_delay   <= delay_t'(WIN);
        // Unused count gets a different value so the mode select shows
        cpt_max         <= trig ? cnt_t'(n_per) : cnt_t'(n_per + 5);
        counter_max     <= trig ? cnt_t'(n_per + 5) : cnt_t'(n_per);
        sweep_dacs = int'(d1) - int'(d0) + 1;
        load_base  = load_count;
        done_base  = done_count;
        served     = cfg_count;
        @(posedge Clk);
        test_start <= 1'b1;
        repeat (2) @(posedge Clk);
        test_start <= 1'b0;
        for (int p = 0; p < n_points; p++) begin
            wait_config_event(served);
            served++;
            if (trig) begin
                emit_trig_point(n_per);
            end else begin
                emit_count_point();
            end
        end
        wait_all_words();
        // FIFO empty, controller reaches WAIT_HOST within two cycles
        repeat (4) @(posedge Clk);
        data_transmit_done <= 1'b1;
        @(posedge Clk);
        data_transmit_done <= 1'b0;
        wait_test_done(done_base);
        repeat (5) @(posedge Clk);
        assert (done_count == done_base + 1)
            else stop_on_error($sformatf("mismatch test_done count exp=%h got=%h",
                                         1, done_count - done_base));
        assert (load_count - load_base == n_points)
            else stop_on_error($sformatf("mismatch sc_param_load count exp=%h got=%h",
                                         n_points, load_count - load_base));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(56529));
        reset_n            = 1'b0;
        test_start         = 1'b0;
        trig_effi_mode     = 1'b1;
        single_chn_mode    = 1'b1;
        single_chn         = '0;
        ctest_inject       = 1'b0;
        cpt_max            = '0;
        counter_max        = '0;
        start_dac          = '0;
        end_dac            = '0;
        trigger_delay      = '0;
        unmask_all         = 1'b0;
        ext_pulse          = 1'b0;
        trigger0_n         = 1'b1;
        trigger1_n         = 1'b1;
        trigger2_n         = 1'b1;
        data_transmit_done = 1'b0;
        full_toggle        = 1'b0;
        repeat (4) @(posedge Clk);
        check_reset_state();
        reset_n <= 1'b1;
        @(posedge Clk);
        check_reset_state();
        full_toggle <= 1'b1;

        // Single channel, trigger efficiency, four DAC points
        run_sweep(1'b1, 1'b1, 6'd5, 1'b1, 1'b0, 10'd100, 10'd103, 4);
        // Injection off, then every discriminator open
        run_sweep(1'b1, 1'b1, 6'd17, 1'b0, 1'b0, 10'd200, 10'd201, 3);
        run_sweep(1'b1, 1'b1, 6'd63, 1'b1, 1'b1, 10'd5, 10'd5, 3);
        // Count efficiency
        run_sweep(1'b0, 1'b1, 6'd2, 1'b1, 1'b0, 10'd10, 10'd12, 10);
        // Every channel, one DAC step
        run_sweep(1'b1, 1'b0, 6'd0, 1'b0, 1'b0, 10'd300, 10'd300, 2);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/scurve_pkg.sv
design/scurve_meas_if.sv
design/inject_pulse_gen.sv
design/scurve_single_test.sv
design/scurve_data_fifo.sv
design/scurve_test_control.sv
design/scurve_test_top.sv
tb/scurve_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the S-curve testbench with Verilator, run it and grep the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module scurve_tb -f all.f -o scurve_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/scurve_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
